/* saturn_glue.f */
rtl/saturn_glue_pkg.sv
rtl/cdd_link.sv
rtl/cd_data_loader.sv
rtl/video_aspect.sv
rtl/debug_keys.sv
rtl/saturn_glue.sv
verif/tb_saturn_glue.sv

/* verif/tb_saturn_glue.sv */
// Testbench for the Saturn console glue
// Directed tests with a CD block model for the drive link

module tb_saturn_glue;
	import saturn_glue_pkg::*;

	logic       clk_sys;
	logic       reset;
	logic       status_valid;
	cdd_frame_t status;
	logic       comclk;
	logic       hdata;
	logic       cdata;
	logic       comreq_n;
	logic       comsync_n;
	logic       cmd_valid;
	cdd_frame_t cmd;
	ioctl_t     ioctl;
	cd_load_t   load;
	logic       vbl_n;
	video_res_t res;
	logic       wide;
	logic       corrected;
	aspect_t    aspect;
	ps2_key_t   ps2_key;
	dbg_ctrl_t  dbg;

	integer     seed = 32'haf0a96c8;
	int         check_count;
	int         error_count;
	int         test_err_start;
	int         cmd_pulses;
	cdd_frame_t cmd_seen;
	cd_load_t   strobe_q [$];
	logic       strobe_prev;
	int         pulse_cnt [0:4];
	dbg_ctrl_t  exp_dbg;

	saturn_glue u_dut (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.status_valid (status_valid),
		.status       (status),
		.comclk       (comclk),
		.hdata        (hdata),
		.cdata        (cdata),
		.comreq_n     (comreq_n),
		.comsync_n    (comsync_n),
		.cmd_valid    (cmd_valid),
		.cmd          (cmd),
		.ioctl        (ioctl),
		.load         (load),
		.vbl_n        (vbl_n),
		.res          (res),
		.wide         (wide),
		.corrected    (corrected),
		.aspect       (aspect),
		.ps2_key      (ps2_key),
		.dbg          (dbg)
	);

	initial clk_sys = 1'b0;
	always #50 clk_sys = ~clk_sys;

	// Strobe and pulse capture away from the active edge
	always @(negedge clk_sys) begin
		if (cmd_valid === 1'b1) begin
			cmd_pulses++;
			cmd_seen = cmd;
		end
		if (load.word_wr === 1'b1 && !strobe_prev)
			strobe_q.push_back(load);
		strobe_prev = (load.word_wr === 1'b1);
		if (dbg.run === 1'b1) pulse_cnt[0]++;
		if (dbg.h320_inc === 1'b1) pulse_cnt[1]++;
		if (dbg.h320_dec === 1'b1) pulse_cnt[2]++;
		if (dbg.h352_inc === 1'b1) pulse_cnt[3]++;
		if (dbg.h352_dec === 1'b1) pulse_cnt[4]++;
	end

	////////////////////////////////////////////////////////////
	// Helpers and compare tasks
	////////////////////////////////////////////////////////////

	task step;
		@(posedge clk_sys);
		#10;
	endtask

	task check_true(input bit ok, input string what);
		check_count++;
		if (!ok) begin
			error_count++;
			$display("%s at time %0t", what, $time);
		end
	endtask

	task compare_bit(input string name, input logic got, input logic exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("Fail time=%0t %s got=%b expected=%b", $time, name, got, exp);
		end
	endtask

	task compare_frame(input string name, input cdd_frame_t got, input cdd_frame_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("Fail time=%0t %s got=%h expected=%h", $time, name, got, exp);
		end
	endtask

	task compare_load(input string name, input cd_load_t got, input cd_load_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("Fail time=%0t %s got=%h expected=%h", $time, name, got, exp);
		end
	endtask

	task compare_aspect(input string name, input aspect_t got, input aspect_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("Fail time=%0t %s got=%0d:%0d expected=%0d:%0d", $time, name,
				got.arx, got.ary, exp.arx, exp.ary);
		end
	endtask

	task compare_dbg(input string name, input dbg_ctrl_t got, input dbg_ctrl_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("Fail time=%0t %s got=%h expected=%h", $time, name, got, exp);
		end
	endtask

	task end_test(input string name);
		if (error_count == test_err_start)
			$display("Test %s: ok", name);
		else
			$display("Test %s: %0d errors", name, error_count - test_err_start);
	endtask

	task wait_comreq_low(input int byte_no);
		int n;
		n = 0;
		while (comreq_n !== 1'b0 && n < 5000) begin
			step;
			n++;
		end
		if (comreq_n !== 1'b0) begin
			error_count++;
			$display("Timeout: no request from the link for byte %0d", byte_no);
		end
	endtask

	task wait_cmd_valid;
		int n;
		n = 0;
		while (cmd_pulses == 0 && n < 5000) begin
			step;
			n++;
		end
		if (cmd_pulses == 0) begin
			error_count++;
			$display("Timeout: cmd_valid never pulsed after the last byte");
		end
	endtask

	// Expected ratios for entries 320x224 to 352x256
	function automatic aspect_t aspect_ref(input int idx, input logic corr);
		case (idx)
			0: return corr ? aspect_t'{8'd10, 8'd7} : aspect_t'{8'd64, 8'd49};
			1: return corr ? aspect_t'{8'd22, 8'd14} : aspect_t'{8'd64, 8'd49};
			2: return corr ? aspect_t'{8'd4, 8'd3} : aspect_t'{8'd128, 8'd105};
			3: return corr ? aspect_t'{8'd22, 8'd15} : aspect_t'{8'd128, 8'd105};
			4: return corr ? aspect_t'{8'd5, 8'd4} : aspect_t'{8'd64, 8'd49};
			default: return corr ? aspect_t'{8'd11, 8'd8} : aspect_t'{8'd128, 8'd105};
		endcase
	endfunction

	function automatic dbg_ctrl_t dbg_with_pulse(input dbg_ctrl_t base, input int k);
		dbg_ctrl_t d;
		d = base;
		case (k)
			0: d.run = 1'b1;
			1: d.h320_inc = 1'b1;
			2: d.h320_dec = 1'b1;
			3: d.h352_inc = 1'b1;
			default: d.h352_dec = 1'b1;
		endcase
		return d;
	endfunction

	task load_write(input logic [7:0] idx, input logic [15:0] data);
		ioctl = '{download: 1'b1, wr: 1'b1, index: idx, data: data};
		step;
		ioctl.wr = 1'b0;
		repeat (7) step;
	endtask

	task press_key(input logic [8:0] code, input logic pressed);
		ps2_key = '{toggle: ~ps2_key.toggle, pressed: pressed, code: code};
		step;
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	task test_reset;
		test_err_start = error_count;
		exp_dbg = '0;
		exp_dbg.scrn_en = 7'h7f;
		exp_dbg.snd_en = 2'b11;
		compare_bit("comreq_n", comreq_n, 1'b1);
		compare_bit("comsync_n", comsync_n, 1'b1);
		compare_bit("cdata", cdata, 1'b0);
		compare_bit("cmd_valid", cmd_valid, 1'b0);
		compare_bit("word_wr", load.word_wr, 1'b0);
		compare_dbg("dbg", dbg, exp_dbg);
		compare_aspect("aspect", aspect, aspect_t'{8'd64, 8'd49});
		end_test("reset values");
	endtask

	task test_link;
		cdd_frame_t status_exp;
		cdd_frame_t cmd_exp;
		cdd_frame_t rx;
		int         b;
		int         i;
		test_err_start = error_count;
		for (b = 0; b < CDD_FRAME_BYTES; b++) begin
			status_exp[b] = 8'($random(seed));
			cmd_exp[b] = 8'($random(seed));
		end
		cmd_pulses = 0;
		rx = '0;
		status = status_exp;
		status_valid = 1'b1;
		step;
		status_valid = 1'b0;
		// CD block side sends one byte per request
		for (b = 0; b < CDD_FRAME_BYTES; b++) begin
			wait_comreq_low(b);
			for (i = 0; i < 8; i++) begin
				comclk = 1'b0;
				hdata = cmd_exp[b][i];
				repeat (3) step;
				rx[b][i] = cdata;
				compare_bit("comsync_n", comsync_n, b != 0);
				comclk = 1'b1;
				repeat (3) step;
			end
		end
		hdata = 1'b0;
		wait_cmd_valid;
		compare_frame("cdata", rx, status_exp);
		compare_frame("cmd", cmd_seen, cmd_exp);
		check_true(cmd_pulses == 1, $sformatf("cmd_valid pulsed %0d times", cmd_pulses));
		// No request may follow the last byte
		repeat (BYTE_GAP_CYCLES + 10) step;
		compare_bit("comreq_n", comreq_n, 1'b1);
		end_test("link exchange");
	endtask

	task test_loader;
		logic [15:0] words [0:2];
		logic [15:0] swapped [0:2];
		cd_load_t    exp;
		int          i;
		test_err_start = error_count;
		words = '{16'h1234, 16'hbe5a, 16'h80c1};
		swapped = '{16'h3412, 16'h5abe, 16'hc180};
		strobe_q.delete();
		load_write(8'h04, 16'h0002);
		for (i = 0; i < 3; i++)
			load_write(8'h04, words[i]);
		ioctl = '0;
		repeat (4) step;
		check_true(strobe_q.size() == 3,
			$sformatf("%0d word strobes seen instead of 3", strobe_q.size()));
		for (i = 0; i < 3; i++) begin
			exp = '{word: swapped[i], word_wr: 1'b1, speed: 1'b0, audio: 1'b1};
			if (i < strobe_q.size())
				compare_load("load", strobe_q[i], exp);
		end
		// Download outside the CD index group
		strobe_q.delete();
		load_write(8'h00, 16'h0002);
		load_write(8'h00, words[0]);
		load_write(8'h00, words[1]);
		ioctl = '0;
		repeat (4) step;
		check_true(strobe_q.size() == 0, "Word strobe seen during a non-CD download");
		end_test("loader");
	endtask

	task test_aspect;
		int         c;
		int         idx;
		video_res_t r;
		test_err_start = error_count;
		for (c = 0; c < 2; c++) begin
			for (idx = 0; idx < 6; idx++) begin
				corrected = c[0];
				r.vres = 2'(idx / 2);
				r.hres = 2'(idx % 2);
				res = r;
				vbl_n = 1'b0;
				step;
				vbl_n = 1'b1;
				repeat (2) step;
				compare_aspect("aspect", aspect, aspect_ref(idx, c[0]));
			end
		end
		// vres 3 falls back to the 224 line entry
		res = '{vres: 2'd3, hres: 2'd1};
		vbl_n = 1'b0;
		step;
		vbl_n = 1'b1;
		repeat (2) step;
		compare_aspect("aspect", aspect, aspect_ref(1, 1'b1));
		res = '0;
		repeat (4) step;
		compare_aspect("aspect", aspect, aspect_ref(1, 1'b1));
		wide = 1'b1;
		step;
		compare_aspect("aspect", aspect, aspect_t'{8'd16, 8'd9});
		wide = 1'b0;
		corrected = 1'b0;
		end_test("aspect");
	endtask

	task test_debug;
		logic [8:0] pulse_keys [0:4];
		int         k;
		int         j;
		test_err_start = error_count;
		press_key(F1, 1'b1);
		exp_dbg.scrn_en[0] = ~exp_dbg.scrn_en[0];
		compare_dbg("dbg", dbg, exp_dbg);
		press_key(F8, 1'b1);
		exp_dbg.snd_en[0] = ~exp_dbg.snd_en[0];
		compare_dbg("dbg", dbg, exp_dbg);
		press_key(F10, 1'b1);
		exp_dbg.brk = ~exp_dbg.brk;
		compare_dbg("dbg", dbg, exp_dbg);
		press_key(PAUSE, 1'b1);
		exp_dbg.pause = ~exp_dbg.pause;
		compare_dbg("dbg", dbg, exp_dbg);
		// Release is ignored
		press_key(F1, 1'b0);
		step;
		compare_dbg("dbg", dbg, exp_dbg);
		// Ordered as run, h320_inc, h320_dec, h352_inc, h352_dec
		pulse_keys = '{F11, KEY_2, KEY_1, KEY_4, KEY_3};
		for (k = 0; k < 5; k++) begin
			for (j = 0; j < 5; j++)
				pulse_cnt[j] = 0;
			press_key(pulse_keys[k], 1'b1);
			compare_dbg("dbg", dbg, dbg_with_pulse(exp_dbg, k));
			repeat (2) step;
			compare_dbg("dbg", dbg, exp_dbg);
			for (j = 0; j < 5; j++)
				check_true(pulse_cnt[j] == ((j == k) ? 1 : 0),
					$sformatf("Pulse bit %0d high for %0d cycles after key %0d",
						j, pulse_cnt[j], k));
		end
		end_test("debug keys");
	endtask

	initial begin
		reset = 1'b1;
		status_valid = 1'b0;
		status = '0;
		comclk = 1'b1;
		hdata = 1'b0;
		ioctl = '0;
		vbl_n = 1'b1;
		res = '0;
		wide = 1'b0;
		corrected = 1'b0;
		ps2_key = '0;
		check_count = 0;
		error_count = 0;
		cmd_pulses = 0;
		strobe_prev = 1'b0;
		for (int j = 0; j < 5; j++)
			pulse_cnt[j] = 0;
		repeat (16) @(posedge clk_sys);
		#10;
		reset = 1'b0;
		step;
		test_reset;
		test_link;
		test_loader;
		test_aspect;
		test_debug;
		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* rtl/saturn_glue.sv */
// Saturn console glue top level
// CD drive link, CD image loader, aspect selector and debug keys on one clock

module saturn_glue (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        status_valid,
	input  saturn_glue_pkg::cdd_frame_t status,
	input  logic                        comclk,
	input  logic                        hdata,
	output logic                        cdata,
	output logic                        comreq_n,
	output logic                        comsync_n,
	output logic                        cmd_valid,
	output saturn_glue_pkg::cdd_frame_t cmd,
	input  saturn_glue_pkg::ioctl_t     ioctl,
	output saturn_glue_pkg::cd_load_t   load,
	input  logic                        vbl_n,
	input  saturn_glue_pkg::video_res_t res,
	input  logic                        wide,
	input  logic                        corrected,
	output saturn_glue_pkg::aspect_t    aspect,
	input  saturn_glue_pkg::ps2_key_t   ps2_key,
	output saturn_glue_pkg::dbg_ctrl_t  dbg
);

	cdd_link u_cdd_link (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.status_valid (status_valid),
		.status       (status),
		.comclk       (comclk),
		.hdata        (hdata),
		.cdata        (cdata),
		.comreq_n     (comreq_n),
		.comsync_n    (comsync_n),
		.cmd_valid    (cmd_valid),
		.cmd          (cmd)
	);

	cd_data_loader u_cd_data_loader (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ioctl   (ioctl),
		.load    (load)
	);

	video_aspect u_video_aspect (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.vbl_n     (vbl_n),
		.res       (res),
		.wide      (wide),
		.corrected (corrected),
		.aspect    (aspect)
	);

	debug_keys u_debug_keys (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ps2_key (ps2_key),
		.dbg     (dbg)
	);

endmodule

/* rtl/debug_keys.sv */
// Debug key decoder
// Function keys flip layer and sound enables, pause and break; run and trim keys pulse

module debug_keys (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  saturn_glue_pkg::ps2_key_t  ps2_key,
	output saturn_glue_pkg::dbg_ctrl_t dbg
);
	import saturn_glue_pkg::*;

	logic toggle_q;
	logic key_event;

	// A new key shows up as a change of the toggle bit
	assign key_event = (ps2_key.toggle != toggle_q) && ps2_key.pressed;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			toggle_q <= 1'b0;
			dbg <= '{scrn_en: '1, snd_en: '1, default: '0};
		end else begin
			toggle_q <= ps2_key.toggle;
			dbg.run <= 1'b0;
			dbg.h320_inc <= 1'b0;
			dbg.h320_dec <= 1'b0;
			dbg.h352_inc <= 1'b0;
			dbg.h352_dec <= 1'b0;
			if (key_event) begin
				case (ps2_key.code)
					F1:    dbg.scrn_en[0] <= ~dbg.scrn_en[0];
					F2:    dbg.scrn_en[1] <= ~dbg.scrn_en[1];
					F3:    dbg.scrn_en[2] <= ~dbg.scrn_en[2];
					F4:    dbg.scrn_en[3] <= ~dbg.scrn_en[3];
					F5:    dbg.scrn_en[4] <= ~dbg.scrn_en[4];
					F6:    dbg.scrn_en[5] <= ~dbg.scrn_en[5];
					F7:    dbg.scrn_en[6] <= ~dbg.scrn_en[6];
					F8:    dbg.snd_en[0] <= ~dbg.snd_en[0];
					F9:    dbg.snd_en[1] <= ~dbg.snd_en[1];
					F10:   dbg.brk <= ~dbg.brk;
					PAUSE: dbg.pause <= ~dbg.pause;
					// Single cycle pulses
					F11:   dbg.run <= 1'b1;
					KEY_1: dbg.h320_dec <= 1'b1;
					KEY_2: dbg.h320_inc <= 1'b1;
					KEY_3: dbg.h352_dec <= 1'b1;
					KEY_4: dbg.h352_inc <= 1'b1;
					default: begin
					end
				endcase
			end
		end
	end

	a_one_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		$onehot0({dbg.run, dbg.h320_inc, dbg.h320_dec, dbg.h352_inc, dbg.h352_dec}));

endmodule

/* rtl/video_aspect.sv */
// Display aspect selector
// Holds the resolution from the start of vertical blank and looks up the aspect ratio

module video_aspect (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        vbl_n,
	input  saturn_glue_pkg::video_res_t res,
	input  logic                        wide,
	input  logic                        corrected,
	output saturn_glue_pkg::aspect_t    aspect
);
	import saturn_glue_pkg::*;

	logic       vbl_q;
	video_res_t res_q;
	logic [1:0] vres_sel;
	logic [2:0] tbl_idx;

	// Resolution stays fixed for the whole frame
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vbl_q <= 1'b1;
			res_q <= '0;
		end else begin
			vbl_q <= vbl_n;
			if (vbl_q && !vbl_n)
				res_q <= res;
		end
	end

	// Unsupported vres falls back to the 224 line entries
	assign vres_sel = (res_q.vres == 2'd3) ? 2'd0 : res_q.vres;

	// hres bit 1 is the hi-res flag and has no effect on the ratio
	assign tbl_idx = {vres_sel, res_q.hres[0]};

	always_comb begin
		if (wide)
			aspect = ASPECT_WIDE;
		else if (corrected)
			aspect = ASPECT_CORR[tbl_idx];
		else
			aspect = ASPECT_ORIG[tbl_idx];
	end

endmodule

/* rtl/cd_data_loader.sv */
// CD image download unpacker
// Takes the speed and audio flags from the header word, then strobes out byte-swapped words

module cd_data_loader (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  saturn_glue_pkg::ioctl_t   ioctl,
	output saturn_glue_pkg::cd_load_t load
);
	import saturn_glue_pkg::*;

	typedef enum logic [1:0] {HEADER, DATA, STROBE} load_state_e;

	load_state_e state;
	logic        cd_download;
	logic [1:0]  strobe_cnt;
	logic [15:0] word_q;
	logic        word_wr;
	logic        speed;
	logic        audio;

	assign cd_download = ioctl.download && (ioctl.index[5:2] == CDD_INDEX);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= HEADER;
			strobe_cnt <= '0;
			word_wr <= 1'b0;
			speed <= 1'b0;
			audio <= 1'b0;
		end else begin
			case (state)
				HEADER: begin
					// Bit 0 selects 2x speed, bit 1 marks CDDA
					if (cd_download && ioctl.wr) begin
						speed <= ioctl.data[0];
						audio <= ioctl.data[1];
						state <= DATA;
					end
				end
				DATA: begin
					if (!cd_download) begin
						state <= HEADER;
					end else if (ioctl.wr) begin
						word_wr <= 1'b1;
						strobe_cnt <= 2'(LOAD_STROBE_CYCLES - 1);
						state <= STROBE;
					end
				end
				STROBE: begin
					// Writes arriving here are dropped
					if (strobe_cnt == 2'd0) begin
						word_wr <= 1'b0;
						state <= DATA;
					end else begin
						strobe_cnt <= strobe_cnt - 2'd1;
					end
				end
				default: state <= HEADER;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (state == DATA && cd_download && ioctl.wr)
			word_q <= {ioctl.data[7:0], ioctl.data[15:8]};
	end

	assign load = '{word: word_q, word_wr: word_wr, speed: speed, audio: audio};

	a_strobe_len: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(word_wr) |-> ##LOAD_STROBE_CYCLES !word_wr);

endmodule

/* rtl/cdd_link.sv */
// CD drive command link
// Shifts the drive status frame out on cdata while the host command frame
// comes in on hdata, both clocked by the CD block through comclk

module cdd_link (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        status_valid,
	input  saturn_glue_pkg::cdd_frame_t status,
	input  logic                        comclk,
	input  logic                        hdata,
	output logic                        cdata,
	output logic                        comreq_n,
	output logic                        comsync_n,
	output logic                        cmd_valid,
	output saturn_glue_pkg::cdd_frame_t cmd
);
	import saturn_glue_pkg::*;

	typedef enum logic [1:0] {IDLE, WAIT_START, BIT, GAP} link_state_e;

	link_state_e state;
	cdd_frame_t  status_q;
	logic [7:0]  tx_byte;
	logic [7:0]  rx_byte;
	logic [7:0]  rx_next;
	logic [3:0]  wait_cnt;
	logic [2:0]  bit_cnt;
	logic [3:0]  byte_cnt;
	logic [9:0]  gap_cnt;
	logic        comclk_q;
	logic        comclk_fall;
	logic        comclk_rise;

	assign comclk_fall = comclk_q & ~comclk;
	assign comclk_rise = ~comclk_q & comclk;

	// LSB first, so new bits enter at the top
	assign rx_next = {hdata, rx_byte[7:1]};

	////////////////////////////////////////////////////////////
	// Exchange control
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		comclk_q <= comclk;
		cmd_valid <= 1'b0;
		if (reset) begin
			state <= IDLE;
			comclk_q <= 1'b1;
			cdata <= 1'b0;
			comreq_n <= 1'b1;
			comsync_n <= 1'b1;
			wait_cnt <= '0;
			bit_cnt <= '0;
			byte_cnt <= '0;
			gap_cnt <= '0;
		end else if (status_valid) begin
			// New status restarts the exchange at byte 0
			state <= WAIT_START;
			wait_cnt <= 4'(START_WAIT_CYCLES);
			comreq_n <= 1'b1;
			comsync_n <= 1'b1;
		end else begin
			case (state)
				WAIT_START: begin
					if (wait_cnt == 4'd0) begin
						comsync_n <= 1'b0;
						bit_cnt <= '0;
						byte_cnt <= '0;
						// Zero gap gives the request one cycle after sync
						gap_cnt <= '0;
						state <= GAP;
					end else begin
						wait_cnt <= wait_cnt - 4'd1;
					end
				end
				GAP: begin
					if (gap_cnt == 10'd0) begin
						comreq_n <= 1'b0;
						state <= BIT;
					end else begin
						gap_cnt <= gap_cnt - 10'd1;
					end
				end
				BIT: begin
					if (comclk_fall)
						cdata <= tx_byte[0];
					if (comclk_rise) begin
						comreq_n <= 1'b1;
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7) begin
							comsync_n <= 1'b1;
							if (byte_cnt == 4'(CDD_FRAME_BYTES - 1)) begin
								cmd_valid <= 1'b1;
								state <= IDLE;
							end else begin
								byte_cnt <= byte_cnt + 4'd1;
								gap_cnt <= 10'(BYTE_GAP_CYCLES - 1);
								state <= GAP;
							end
						end
					end
				end
				default: begin
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Frame and shift registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (status_valid)
			status_q <= status;
		if (state == WAIT_START && wait_cnt == 4'd0)
			tx_byte <= status_q[0];
		if (state == BIT) begin
			if (comclk_fall)
				tx_byte <= {1'b0, tx_byte[7:1]};
			if (comclk_rise) begin
				rx_byte <= rx_next;
				if (bit_cnt == 3'd7) begin
					cmd[byte_cnt] <= rx_next;
					if (byte_cnt != 4'(CDD_FRAME_BYTES - 1))
						tx_byte <= status_q[byte_cnt + 4'd1];
				end
			end
		end
	end

	a_cmd_valid_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		cmd_valid |=> !cmd_valid);

	// Sync may only be asserted while a frame is in flight
	a_sync_idle: assert property (@(posedge clk_sys) disable iff (reset)
		(state == IDLE) |-> comsync_n);

endmodule

/* rtl/saturn_glue_pkg.sv */
// Shared definitions for the Saturn console glue blocks
// Frame sizes, link timing, bus structs, debug key codes and aspect tables

package saturn_glue_pkg;

	////////////////////////////////////////////////////////////
	// CD drive link and loader timing
	////////////////////////////////////////////////////////////

	localparam int CDD_FRAME_BYTES = 12;
	localparam int START_WAIT_CYCLES = 15;
	localparam int BYTE_GAP_CYCLES = 1023;
	localparam int LOAD_STROBE_CYCLES = 4;

	// Index group of a CD image download
	localparam logic [3:0] CDD_INDEX = 4'd1;

	// Byte 0 goes out first
	typedef logic [CDD_FRAME_BYTES-1:0][7:0] cdd_frame_t;

	typedef struct packed {
		logic        download;
		logic        wr;
		logic [7:0]  index;
		logic [15:0] data;
	} ioctl_t;

	typedef struct packed {
		logic [15:0] word;
		logic        word_wr;
		logic        speed;
		logic        audio;
	} cd_load_t;

	////////////////////////////////////////////////////////////
	// Debug keyboard
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic [8:0] code;
	} ps2_key_t;

	// PS/2 set 2 codes, bit 8 marks an extended key
	typedef enum logic [8:0] {
		F1     = 9'h005,
		F2     = 9'h006,
		F3     = 9'h004,
		F4     = 9'h00c,
		F5     = 9'h003,
		F6     = 9'h00b,
		F7     = 9'h083,
		F8     = 9'h00a,
		F9     = 9'h001,
		F10    = 9'h009,
		F11    = 9'h078,
		PAUSE  = 9'h177,
		KEY_1  = 9'h016,
		KEY_2  = 9'h01e,
		KEY_3  = 9'h026,
		KEY_4  = 9'h025
	} dbg_key_e;

	typedef struct packed {
		logic [6:0] scrn_en;
		logic [1:0] snd_en;
		logic       pause;
		logic       brk;
		logic       run;
		logic       h320_inc;
		logic       h320_dec;
		logic       h352_inc;
		logic       h352_dec;
	} dbg_ctrl_t;

	////////////////////////////////////////////////////////////
	// Video aspect
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [1:0] vres;
		logic [1:0] hres;
	} video_res_t;

	typedef struct packed {
		logic [7:0] arx;
		logic [7:0] ary;
	} aspect_t;

	// 320x224, 352x224, 320x240, 352x240, 320x256, 352x256
	localparam aspect_t ASPECT_ORIG [0:5] = '{
		'{8'd64, 8'd49}, '{8'd64, 8'd49}, '{8'd128, 8'd105},
		'{8'd128, 8'd105}, '{8'd64, 8'd49}, '{8'd128, 8'd105}
	};
	localparam aspect_t ASPECT_CORR [0:5] = '{
		'{8'd10, 8'd7}, '{8'd22, 8'd14}, '{8'd4, 8'd3},
		'{8'd22, 8'd15}, '{8'd5, 8'd4}, '{8'd11, 8'd8}
	};
	localparam aspect_t ASPECT_WIDE = '{8'd16, 8'd9};

endpackage
